// ==== hdl/rob_pkg.sv ====
/* shared widths, vector types and lane structs for the two-way reorder buffer */

package rob_pkg;

    // dispatch and commit width
    localparam int WAYS      = 2;
    localparam int ROB_DEPTH = 16;
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;
    localparam int XLEN      = 32;

    typedef logic [$clog2(ARCH_REGS)-1:0] arn_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] prn_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;
    // one extra bit so a completely free buffer fits
    typedef logic [$clog2(ROB_DEPTH):0]   rob_count_t;
    typedef logic [XLEN-1:0]              addr_t;

    // one renamed instruction from the dispatch side
    typedef struct packed {
        logic  valid;
        arn_t  arn;
        prn_t  prn;
        logic  reg_write;
        logic  is_branch;
        logic  is_store;
        addr_t pc;
        logic  pred_taken;
        addr_t pred_target;
        logic  illegal;
        logic  halt;
    } disp_slot_t;

    // one CDB completion strobe
    typedef struct packed {
        logic     valid;
        rob_idx_t idx;
        logic     taken;
        addr_t    target;
    } cdb_slot_t;

    // stored slot, direction and target are overwritten on completion
    typedef struct packed {
        arn_t  arn;
        prn_t  prn;
        logic  reg_write;
        logic  is_branch;
        logic  is_store;
        addr_t pc;
        logic  taken;
        addr_t target;
        logic  illegal;
        logic  halt;
        logic  done;
        logic  mispredicted;
    } rob_entry_t;

    typedef struct packed {
        logic  valid;
        arn_t  arn;
        prn_t  prn;
        logic  reg_write;
        addr_t pc;
    } commit_slot_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t idx;
    } alloc_slot_t;

endpackage

// ==== hdl/dispatch_stage.sv ====
/* dispatch stage: one-deep bundle register, ROB space stall
   and flush clear */

`timescale 1ns/1ps

module dispatch_stage (
    input  logic                                    clock,
    input  logic                                    arst_n,
    input  rob_pkg::disp_slot_t [rob_pkg::WAYS-1:0] disp_in,
    output logic                                    disp_ready,
    input  rob_pkg::rob_count_t                     free_slots,
    input  logic                                    halted,
    input  logic                                    flush,
    output logic                                    move,
    output rob_pkg::disp_slot_t [rob_pkg::WAYS-1:0] held
);

    // low during reset, high from the first edge on
    logic live;
    logic held_any;
    logic in_any;
    logic take;

    // lanes fill from lane 0, so any valid bit means a bundle
    always_comb begin
        held_any = 1'b0;
        in_any   = 1'b0;
        for (int i = 0; i < rob_pkg::WAYS; i++) begin
            held_any = held_any | held[i].valid;
            in_any   = in_any | disp_in[i].valid;
        end
    end

    // hand over only when a full group fits
    // a flush cycle discards the bundle instead of allocating it
    assign move = held_any
                  && (free_slots >= rob_pkg::rob_count_t'(rob_pkg::WAYS))
                  && !flush;

    // empty or leaving this cycle
    assign disp_ready = live && !halted && !flush && (!held_any || move);

    assign take = disp_ready && in_any;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            live <= 1'b0;
        end else begin
            live <= 1'b1;
        end
    end

    // bundle register
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            held <= '0;
        end else if (flush) begin
            // wrong path, drop it
            held <= '0;
        end else if (take) begin
            // replaces a bundle that is moving this cycle
            held <= disp_in;
        end else if (move) begin
            held <= '0;
        end
    end

endmodule

// ==== hdl/reorder_buffer.sv ====
/* reorder buffer: circular entry array, CDB completion,
   in-order two-way commit group and mispredict flush */

`timescale 1ns/1ps

module reorder_buffer (
    input  logic                                      clock,
    input  logic                                      arst_n,
    input  logic                                      move,
    input  rob_pkg::disp_slot_t [rob_pkg::WAYS-1:0]   held,
    input  rob_pkg::cdb_slot_t [rob_pkg::WAYS-1:0]    cdb_in,
    output rob_pkg::alloc_slot_t [rob_pkg::WAYS-1:0]  alloc_out,
    output rob_pkg::rob_count_t                       free_slots,
    output rob_pkg::commit_slot_t [rob_pkg::WAYS-1:0] commit,
    output logic                                      flush,
    output rob_pkg::addr_t                            flush_pc,
    output logic                                      commit_halt,
    output logic                                      commit_illegal
);

    rob_pkg::rob_entry_t [rob_pkg::ROB_DEPTH-1:0] entries;
    rob_pkg::rob_idx_t                            head;
    rob_pkg::rob_idx_t                            tail;
    // set once a halt or illegal entry commits, nothing commits after it
    logic                                         stopped;

    rob_pkg::rob_count_t                          used_slots;
    logic [rob_pkg::ROB_DEPTH-1:0]                occupied;
    rob_pkg::rob_count_t                          n_disp;
    rob_pkg::rob_count_t                          n_commit;
    rob_pkg::rob_entry_t [rob_pkg::WAYS-1:0]      fresh;

    assign used_slots = rob_pkg::rob_count_t'(rob_pkg::ROB_DEPTH) - free_slots;

    // slot s is live if it sits less than used_slots past head
    always_comb begin
        rob_pkg::rob_idx_t offset;
        for (int s = 0; s < rob_pkg::ROB_DEPTH; s++) begin
            offset      = rob_pkg::rob_idx_t'(s) - head;
            occupied[s] = rob_pkg::rob_count_t'(offset) < used_slots;
        end
    end

    // allocation, lane i goes to tail + i
    always_comb begin
        n_disp    = '0;
        alloc_out = '0;
        for (int i = 0; i < rob_pkg::WAYS; i++) begin
            fresh[i].arn          = held[i].arn;
            fresh[i].prn          = held[i].prn;
            fresh[i].reg_write    = held[i].reg_write;
            fresh[i].is_branch    = held[i].is_branch;
            fresh[i].is_store     = held[i].is_store;
            fresh[i].pc           = held[i].pc;
            fresh[i].taken        = held[i].pred_taken;
            fresh[i].target       = held[i].pred_target;
            fresh[i].illegal      = held[i].illegal;
            fresh[i].halt         = held[i].halt;
            fresh[i].done         = 1'b0;
            fresh[i].mispredicted = 1'b0;
            if (move && held[i].valid) begin
                alloc_out[i].valid = 1'b1;
                alloc_out[i].idx   = tail + rob_pkg::rob_idx_t'(i);
                n_disp             = n_disp + 1'b1;
            end
        end
    end

    // commit group: longest run of done entries from head
    always_comb begin
        rob_pkg::rob_idx_t   idx;
        rob_pkg::rob_entry_t cand;
        logic                stop;
        logic                store_seen;
        commit         = '0;
        n_commit       = '0;
        flush          = 1'b0;
        flush_pc       = '0;
        commit_halt    = 1'b0;
        commit_illegal = 1'b0;
        stop           = stopped;
        store_seen     = 1'b0;
        for (int i = 0; i < rob_pkg::WAYS; i++) begin
            idx  = head + rob_pkg::rob_idx_t'(i);
            cand = entries[idx];
            // a second store waits for the next cycle
            if (!stop && occupied[idx] && cand.done && !(cand.is_store && store_seen)) begin
                commit[i].valid     = 1'b1;
                commit[i].arn       = cand.arn;
                commit[i].prn       = cand.prn;
                commit[i].reg_write = cand.reg_write;
                commit[i].pc        = cand.pc;
                n_commit            = n_commit + 1'b1;
                store_seen          = store_seen | cand.is_store;
                commit_halt         = commit_halt | cand.halt;
                commit_illegal      = commit_illegal | cand.illegal;
                if (cand.mispredicted) begin
                    flush = 1'b1;
                    // resolved direction picks the refetch address
                    flush_pc = cand.taken ? cand.target : cand.pc + rob_pkg::addr_t'(4);
                end
                // nothing younger joins a halt, illegal or mispredict
                stop = cand.halt | cand.illegal | cand.mispredicted;
            end else begin
                stop = 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            entries    <= '0;
            head       <= '0;
            tail       <= '0;
            free_slots <= rob_pkg::rob_count_t'(rob_pkg::ROB_DEPTH);
            stopped    <= 1'b0;
        end else if (flush) begin
            // everything behind the branch is wrong path
            entries    <= '0;
            head       <= '0;
            tail       <= '0;
            free_slots <= rob_pkg::rob_count_t'(rob_pkg::ROB_DEPTH);
        end else begin
            for (int i = 0; i < rob_pkg::WAYS; i++) begin
                if (alloc_out[i].valid) begin
                    entries[alloc_out[i].idx] <= fresh[i];
                end
            end
            // strobes for empty slots are dropped
            for (int i = 0; i < rob_pkg::WAYS; i++) begin
                if (cdb_in[i].valid && occupied[cdb_in[i].idx]) begin
                    entries[cdb_in[i].idx].done   <= 1'b1;
                    // compare against the predicted target before overwrite
                    entries[cdb_in[i].idx].mispredicted <=
                        entries[cdb_in[i].idx].is_branch
                        && (cdb_in[i].target != entries[cdb_in[i].idx].target);
                    entries[cdb_in[i].idx].taken  <= cdb_in[i].taken;
                    entries[cdb_in[i].idx].target <= cdb_in[i].target;
                end
            end
            head       <= head + rob_pkg::rob_idx_t'(n_commit);
            tail       <= tail + rob_pkg::rob_idx_t'(n_disp);
            free_slots <= free_slots - n_disp + n_commit;
            stopped    <= stopped | commit_halt | commit_illegal;
        end
    end

endmodule

// ==== hdl/retire_unit.sv ====
/* retire unit: architectural map table, freed register report,
   fetch redirect register and sticky halt flags */

`timescale 1ns/1ps

module retire_unit (
    input  logic                                      clock,
    input  logic                                      arst_n,
    input  rob_pkg::commit_slot_t [rob_pkg::WAYS-1:0] commit,
    input  logic                                      flush,
    input  rob_pkg::addr_t                            flush_pc,
    input  logic                                      commit_halt,
    input  logic                                      commit_illegal,
    output logic [rob_pkg::WAYS-1:0]                  retire_valid,
    output rob_pkg::arn_t [rob_pkg::WAYS-1:0]         retire_arn,
    output rob_pkg::prn_t [rob_pkg::WAYS-1:0]         retire_prn,
    output rob_pkg::prn_t [rob_pkg::WAYS-1:0]         freed_prn,
    output logic                                      redirect_valid,
    output rob_pkg::addr_t                            redirect_pc,
    output logic                                      halted,
    output logic                                      illegal_seen
);

    // committed arch to phys mapping
    rob_pkg::prn_t [rob_pkg::ARCH_REGS-1:0] map_q;
    rob_pkg::prn_t [rob_pkg::ARCH_REGS-1:0] map_next;
    rob_pkg::prn_t [rob_pkg::WAYS-1:0]      freed;

    // lanes walk in order so lane 1 sees lane 0's write
    // non-writing lanes free nothing and report zero
    always_comb begin
        map_next = map_q;
        freed    = '0;
        for (int i = 0; i < rob_pkg::WAYS; i++) begin
            if (commit[i].valid && commit[i].reg_write) begin
                freed[i]                 = map_next[commit[i].arn];
                map_next[commit[i].arn]  = commit[i].prn;
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            // identity map out of reset
            for (int r = 0; r < rob_pkg::ARCH_REGS; r++) begin
                map_q[r] <= rob_pkg::prn_t'(r);
            end
        end else begin
            map_q <= map_next;
        end
    end

    // retirement report, one cycle after the commit cycle
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            retire_valid <= '0;
            retire_arn   <= '0;
            retire_prn   <= '0;
            freed_prn    <= '0;
        end else begin
            for (int i = 0; i < rob_pkg::WAYS; i++) begin
                retire_valid[i] <= commit[i].valid;
                retire_arn[i]   <= commit[i].arn;
                retire_prn[i]   <= commit[i].prn;
            end
            freed_prn <= freed;
        end
    end

    // redirect pulse and sticky stop flags
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            redirect_valid <= 1'b0;
            redirect_pc    <= '0;
            halted         <= 1'b0;
            illegal_seen   <= 1'b0;
        end else begin
            redirect_valid <= flush;
            if (flush) begin
                redirect_pc <= flush_pc;
            end
            // an illegal instruction stops the core as a halt does
            halted       <= halted | commit_halt | commit_illegal;
            illegal_seen <= illegal_seen | commit_illegal;
        end
    end

endmodule

// ==== hdl/rob_core.sv ====
/* top level: dispatch stage, reorder buffer and retire unit */

`timescale 1ns/1ps

module rob_core (
    input  logic                                     clock,
    input  logic                                     arst_n,
    input  rob_pkg::disp_slot_t [rob_pkg::WAYS-1:0]  disp_in,
    input  rob_pkg::cdb_slot_t [rob_pkg::WAYS-1:0]   cdb_in,
    output logic                                     disp_ready,
    output rob_pkg::alloc_slot_t [rob_pkg::WAYS-1:0] alloc_out,
    output logic [rob_pkg::WAYS-1:0]                 retire_valid,
    output rob_pkg::arn_t [rob_pkg::WAYS-1:0]        retire_arn,
    output rob_pkg::prn_t [rob_pkg::WAYS-1:0]        retire_prn,
    output rob_pkg::prn_t [rob_pkg::WAYS-1:0]        freed_prn,
    output logic                                     redirect_valid,
    output rob_pkg::addr_t                           redirect_pc,
    output logic                                     halted,
    output logic                                     illegal_seen
);

    // dispatch to buffer
    logic                                      move;
    rob_pkg::disp_slot_t [rob_pkg::WAYS-1:0]   held;
    rob_pkg::rob_count_t                       free_slots;

    // buffer to retire unit
    rob_pkg::commit_slot_t [rob_pkg::WAYS-1:0] commit;
    logic                                      flush;
    rob_pkg::addr_t                            flush_pc;
    logic                                      commit_halt;
    logic                                      commit_illegal;

    dispatch_stage i_dispatch_stage (
        .clock      (clock),
        .arst_n     (arst_n),
        .disp_in    (disp_in),
        .disp_ready (disp_ready),
        .free_slots (free_slots),
        .halted     (halted),
        .flush      (flush),
        .move       (move),
        .held       (held)
    );

    reorder_buffer i_reorder_buffer (
        .clock          (clock),
        .arst_n         (arst_n),
        .move           (move),
        .held           (held),
        .cdb_in         (cdb_in),
        .alloc_out      (alloc_out),
        .free_slots     (free_slots),
        .commit         (commit),
        .flush          (flush),
        .flush_pc       (flush_pc),
        .commit_halt    (commit_halt),
        .commit_illegal (commit_illegal)
    );

    retire_unit i_retire_unit (
        .clock          (clock),
        .arst_n         (arst_n),
        .commit         (commit),
        .flush          (flush),
        .flush_pc       (flush_pc),
        .commit_halt    (commit_halt),
        .commit_illegal (commit_illegal),
        .retire_valid   (retire_valid),
        .retire_arn     (retire_arn),
        .retire_prn     (retire_prn),
        .freed_prn      (freed_prn),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .halted         (halted),
        .illegal_seen   (illegal_seen)
    );

endmodule

// ==== bench/tb_rob_core.sv ====
/* testbench for the two-way reorder buffer core with LFSR stimulus,
   queue model with map table, retirement checks, watchdog and summary */

`timescale 1ns/1ps

module tb_rob_core;

    // random traffic cycles per test before the drain
    localparam int TEST_CYCLES = 120;
    localparam int N_TESTS     = 6;
    localparam int STIM_CYCLES = TEST_CYCLES * N_TESTS;

    // model slot holding the instruction and its completion state
    typedef struct packed {
        rob_pkg::disp_slot_t ins;
        rob_pkg::rob_idx_t   idx;
        logic                done;
        logic                miss;
        logic                taken;
        rob_pkg::addr_t      target;
    } model_entry_t;

    logic                                     clock;
    logic                                     arst_n;
    rob_pkg::disp_slot_t  [rob_pkg::WAYS-1:0] disp_in;
    rob_pkg::cdb_slot_t   [rob_pkg::WAYS-1:0] cdb_in;
    logic                                     disp_ready;
    rob_pkg::alloc_slot_t [rob_pkg::WAYS-1:0] alloc_out;
    logic [rob_pkg::WAYS-1:0]                 retire_valid;
    rob_pkg::arn_t [rob_pkg::WAYS-1:0]        retire_arn;
    rob_pkg::prn_t [rob_pkg::WAYS-1:0]        retire_prn;
    rob_pkg::prn_t [rob_pkg::WAYS-1:0]        freed_prn;
    logic                                     redirect_valid;
    rob_pkg::addr_t                           redirect_pc;
    logic                                     halted;
    logic                                     illegal_seen;

    // model state
    model_entry_t        rob_q[$];
    rob_pkg::disp_slot_t pend_q[$];
    rob_pkg::prn_t       arch_map [rob_pkg::ARCH_REGS];
    rob_pkg::rob_idx_t   exp_tail;
    logic                model_halted;
    rob_pkg::addr_t      next_pc;
    logic [31:0]         lfsr_q;
    int                  checks;
    int                  errors;
    int                  retired;
    int                  redirects;
    int                  err_mark;
    int                  ret_mark;

    // stimulus knobs
    logic gen_on;
    logic cdb_on;
    logic br_on;
    logic miss_on;
    logic two_lanes;
    logic narrow_arn;
    logic halt_next;
    int   store_bits;

    rob_core i_rob_core (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin
        repeat (STIM_CYCLES * 40) @(posedge clock);
        $display("watchdog expired after %0d cycles, the run did not finish", STIM_CYCLES * 40);
        $display("TEST FAIL");
        $finish;
    end

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            r      = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("%0t: %s", $time, what);
        end
    endtask

    // compare the retirement stream with the model head from the oldest lane
    task automatic check_retire();
        model_entry_t e;
        int           stores;
        logic         group_end;
        logic         flushed;
        stores    = 0;
        group_end = 1'b0;
        flushed   = 1'b0;
        for (int i = 0; i < rob_pkg::WAYS; i++) begin
            if (retire_valid[i]) begin
                check_true(!group_end && !model_halted,
                           "instruction retired after a halt or mispredict");
                check_true(rob_q.size() > 0, "retirement with no instruction outstanding");
                if (rob_q.size() > 0 && !group_end && !model_halted) begin
                    e = rob_q.pop_front();
                    retired++;
                    check_true(e.done, "instruction retired before its completion");
                    check_hex("retire_arn", retire_arn[i], e.ins.arn);
                    check_hex("retire_prn", retire_prn[i], e.ins.prn);
                    if (e.ins.reg_write) begin
                        // previous mapping is the register freed
                        check_hex("freed_prn", freed_prn[i], arch_map[e.ins.arn]);
                        arch_map[e.ins.arn] = e.ins.prn;
                    end
                    stores += int'(e.ins.is_store);
                    if (e.miss) begin
                        flushed   = 1'b1;
                        group_end = 1'b1;
                        redirects++;
                        check_hex("redirect_pc", redirect_pc, e.taken ? e.target : e.ins.pc + 4);
                    end
                    if (e.ins.halt) begin
                        model_halted = 1'b1;
                        group_end    = 1'b1;
                    end
                end
            end
        end
        check_true(stores < 2, "two stores retired in one cycle");
        check_hex("redirect_valid", redirect_valid, flushed);
        check_hex("halted", halted, model_halted);
        check_hex("illegal_seen", illegal_seen, 0);
        check_true(!(model_halted && disp_ready), "disp_ready high while halted");
        // everything younger than the branch is wrong path
        if (flushed) begin
            rob_q.delete();
            pend_q.delete();
            exp_tail = '0;
        end
    endtask

    // random out of order completions for slots allocated earlier
    task automatic drive_cdb();
        model_entry_t e;
        int           pos;
        cdb_in = '0;
        for (int l = 0; l < rob_pkg::WAYS; l++) begin
            if (cdb_on && rob_q.size() > 0 && take_bits(1) != 0) begin
                pos = int'(take_bits(4)) % rob_q.size();
                e   = rob_q[pos];
                if (!e.done) begin
                    e.done   = 1'b1;
                    e.taken  = 1'(take_bits(1));
                    e.target = e.ins.pred_target;
                    if (miss_on && take_bits(2) == 0) begin
                        e.target = e.ins.pred_target ^ 32'h40;
                    end
                    e.miss     = e.ins.is_branch && (e.target != e.ins.pred_target);
                    rob_q[pos] = e;
                    cdb_in[l].valid  = 1'b1;
                    cdb_in[l].idx    = e.idx;
                    cdb_in[l].taken  = e.taken;
                    cdb_in[l].target = e.target;
                end
            end
        end
    endtask

    // slots come from tail and run on modulo depth
    task automatic record_alloc();
        model_entry_t e;
        for (int l = 0; l < rob_pkg::WAYS; l++) begin
            if (alloc_out[l].valid) begin
                check_true(pend_q.size() > 0, "allocation with no accepted instruction waiting");
                check_hex("alloc_out.idx", alloc_out[l].idx, exp_tail);
                if (pend_q.size() > 0) begin
                    e     = '0;
                    e.ins = pend_q.pop_front();
                    e.idx = alloc_out[l].idx;
                    rob_q.push_back(e);
                end
                exp_tail++;
            end
        end
    endtask

    // only offered when ready, so every driven bundle is taken
    task automatic drive_disp();
        rob_pkg::disp_slot_t s;
        int                  lanes;
        disp_in = '0;
        if (gen_on && disp_ready && take_bits(1) != 0) begin
            lanes = (two_lanes || take_bits(1) != 0) ? 2 : 1;
            for (int l = 0; l < lanes; l++) begin
                s             = '0;
                s.valid       = 1'b1;
                s.arn         = narrow_arn ? take_bits(2) : take_bits(5);
                s.prn         = take_bits(6);
                s.reg_write   = take_bits(2) != 0;
                s.is_branch   = br_on && take_bits(2) == 0;
                s.is_store    = !s.is_branch && take_bits(store_bits) == 0;
                s.pc          = next_pc;
                s.pred_taken  = 1'(take_bits(1));
                s.pred_target = 32'h1000 + (take_bits(8) << 2);
                s.halt        = halt_next && (l == 0);
                next_pc       = next_pc + 4;
                disp_in[l]    = s;
                pend_q.push_back(s);
            end
            halt_next = 1'b0;
        end
    endtask

    // sample first and drive afterwards on the falling edge
    task automatic run_cycle();
        @(negedge clock);
        check_retire();
        drive_cdb();
        record_alloc();
        drive_disp();
    endtask

    task automatic set_knobs(input logic br, input logic miss, input logic two,
                             input logic narrow, input int st_bits);
        br_on      = br;
        miss_on    = miss;
        two_lanes  = two;
        narrow_arn = narrow;
        store_bits = st_bits;
        gen_on     = 1'b1;
        cdb_on     = 1'b1;
        err_mark   = errors;
        ret_mark   = retired;
        redirects  = 0;
    endtask

    task automatic finish_test(input int num, input string name, input logic drain_it);
        gen_on = 1'b0;
        cdb_on = 1'b1;
        while (drain_it && (rob_q.size() > 0 || pend_q.size() > 0)) begin
            run_cycle();
        end
        // a few quiet cycles where nothing may retire
        repeat (4) run_cycle();
        $display("test %0d %s: retired %0d, redirects %0d, errors %0d",
                 num, name, retired - ret_mark, redirects, errors - err_mark);
    endtask

    initial begin
        disp_in      = '0;
        cdb_in       = '0;
        arst_n       = 1'b0;
        lfsr_q       = 32'hf210;
        checks       = 0;
        errors       = 0;
        retired      = 0;
        exp_tail     = '0;
        model_halted = 1'b0;
        next_pc      = 32'h100;
        halt_next    = 1'b0;
        set_knobs(1'b0, 1'b0, 1'b0, 1'b0, 2);
        gen_on = 1'b0;
        for (int r = 0; r < rob_pkg::ARCH_REGS; r++) begin
            arch_map[r] = rob_pkg::prn_t'(r);
        end
        repeat (8) @(posedge clock);
        @(negedge clock);
        // outputs quiet in reset
        check_hex("disp_ready", disp_ready, 0);
        check_hex("retire_valid", retire_valid, 0);
        check_hex("redirect_valid", redirect_valid, 0);
        check_hex("alloc_out[0].valid", alloc_out[0].valid, 0);
        check_hex("alloc_out[1].valid", alloc_out[1].valid, 0);
        arst_n = 1'b1;

        // correct predictions with random completion order
        set_knobs(1'b1, 1'b0, 1'b0, 1'b0, 2);
        repeat (TEST_CYCLES) run_cycle();
        finish_test(1, "in-order retirement", 1'b1);

        set_knobs(1'b1, 1'b1, 1'b0, 1'b0, 2);
        repeat (TEST_CYCLES) run_cycle();
        finish_test(2, "mispredict flush", 1'b1);
        check_true(redirects > 0, "no mispredicted branch reached retirement");

        // half of all instructions are stores
        set_knobs(1'b0, 1'b0, 1'b0, 1'b0, 1);
        repeat (TEST_CYCLES) run_cycle();
        finish_test(3, "store limit", 1'b1);

        // only four registers so the same arn often appears twice in a group
        set_knobs(1'b0, 1'b0, 1'b1, 1'b1, 2);
        repeat (TEST_CYCLES) run_cycle();
        finish_test(4, "map table", 1'b1);

        // fill all 16 slots with a bundle stalled behind them
        set_knobs(1'b0, 1'b0, 1'b1, 1'b0, 2);
        cdb_on = 1'b0;
        while (rob_q.size() < rob_pkg::ROB_DEPTH || pend_q.size() == 0) begin
            run_cycle();
        end
        repeat (3) run_cycle();
        check_hex("disp_ready", disp_ready, 0);
        check_hex("model slots", rob_q.size(), rob_pkg::ROB_DEPTH);
        finish_test(5, "full buffer", 1'b1);

        // halt in the middle of traffic
        set_knobs(1'b0, 1'b0, 1'b0, 1'b0, 2);
        repeat (20) run_cycle();
        halt_next = 1'b1;
        for (int c = 0; c < TEST_CYCLES && !model_halted; c++) begin
            run_cycle();
        end
        check_true(model_halted, "halt instruction never retired");
        repeat (20) run_cycle();
        finish_test(6, "halt", 1'b0);

        $display("summary: %0d tests, %0d checks, %0d retired, %0d errors",
                 N_TESTS, checks, retired, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== project.f ====
hdl/rob_pkg.sv
hdl/dispatch_stage.sv
hdl/reorder_buffer.sv
hdl/retire_unit.sv
hdl/rob_core.sv
bench/tb_rob_core.sv

// ==== run.sh ====
#!/bin/sh
# build the reorder buffer testbench with Verilator, run it, then scan the log

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_rob_core -o tb_rob_core \
    && ./obj_dir/tb_rob_core > sim.log 2>&1 \
    || { echo "build or simulation error"; exit 1; }

cat sim.log

grep -q "TEST FAIL" sim.log \
    && { echo "result: failed"; exit 1; } \
    || { echo "result: passed"; exit 0; }
